// File: source/xgmii_pkg.sv
package xgmii_pkg;

  localparam int lane_width = 8;
  localparam int lane_count = 8;

  typedef logic [6:0] ctl_code_t;

  // ordered sets are flagged apart from these.
  typedef enum logic [1:0] {
    kind_data,
    kind_ctrl,
    kind_start,
    kind_term
  } lane_kind_t;

  localparam logic [lane_width-1:0] char_idle    = 8'h07;
  localparam logic [lane_width-1:0] char_start   = 8'hfb;
  localparam logic [lane_width-1:0] char_term    = 8'hfd;
  localparam logic [lane_width-1:0] char_error   = 8'hfe;
  localparam logic [lane_width-1:0] char_order   = 8'h9c; // sequence ordered set.
  localparam logic [lane_width-1:0] char_fsig    = 8'h5c; // signal ordered set.
  localparam logic [lane_width-1:0] char_idle_r  = 8'h1c;
  localparam logic [lane_width-1:0] char_idle_a  = 8'h7c;
  localparam logic [lane_width-1:0] char_idle_k  = 8'hbc;
  localparam logic [lane_width-1:0] char_code_3c = 8'h3c;
  localparam logic [lane_width-1:0] char_code_dc = 8'hdc;
  localparam logic [lane_width-1:0] char_code_f7 = 8'hf7;

  // 7-bit codes carried in control blocks.
  localparam ctl_code_t ctl_idle   = 7'h00;
  localparam ctl_code_t ctl_idle_a = 7'h4b;
  localparam ctl_code_t ctl_idle_k = 7'h55;
  localparam ctl_code_t ctl_idle_r = 7'h2d;
  localparam ctl_code_t ctl_3c     = 7'h33;
  localparam ctl_code_t ctl_dc     = 7'h66;
  localparam ctl_code_t ctl_f7     = 7'h78;
  localparam ctl_code_t ctl_error  = 7'h1e;

endpackage

// File: source/pcs_block_pkg.sv
package pcs_block_pkg;

  localparam int block_width   = 66;
  localparam int payload_width = 64;
  localparam int scram_width   = 58;

  // sync header in [1:0], type field in [9:2].
  typedef logic [block_width-1:0] block_t;
  typedef logic [7:0] block_type_t;

  localparam logic [1:0] sync_data = 2'b10;
  localparam logic [1:0] sync_ctrl = 2'b01;

  localparam logic [3:0] order_fsig = 4'hf;

  localparam block_type_t type_ctrl       = 8'h1e; // also the error block.
  localparam block_type_t type_ctrl_ord   = 8'h2d;
  localparam block_type_t type_ctrl_start = 8'h33;
  localparam block_type_t type_ord_start  = 8'h66;
  localparam block_type_t type_ord_ord    = 8'h55;
  localparam block_type_t type_start      = 8'h78;
  localparam block_type_t type_ord_ctrl   = 8'h4b;

  // indexed by terminate lane.
  localparam block_type_t type_term [8] = '{
    8'h87,
    8'h99,
    8'haa,
    8'hb4,
    8'hcc,
    8'hd2,
    8'he1,
    8'hff
  };

endpackage

// File: source/control_lane_decoder.sv
`timescale 1ns/1ps

module control_lane_decoder (
  input  logic [xgmii_pkg::lane_width-1:0] lane_char,
  input  logic                             is_ctrl,
  output xgmii_pkg::lane_kind_t            lane_kind,
  output logic                             is_order,
  output logic                             is_fsig,
  output xgmii_pkg::ctl_code_t             ctl_code
);
  import xgmii_pkg::*;

  always_comb
  begin
    lane_kind = kind_ctrl;
    is_order = 1'b0;
    is_fsig = 1'b0;
    ctl_code = ctl_error; // unknown characters keep this.
    if (!is_ctrl)
    begin
      lane_kind = kind_data;
      ctl_code = ctl_idle;
    end
    else
      case (lane_char)
        char_start:   lane_kind = kind_start;
        char_term:    lane_kind = kind_term;
        char_order:   is_order = 1'b1;
        char_fsig:
        begin
          is_order = 1'b1;
          is_fsig = 1'b1;
        end
        char_idle:    ctl_code = ctl_idle;
        char_idle_a:  ctl_code = ctl_idle_a;
        char_idle_k:  ctl_code = ctl_idle_k;
        char_idle_r:  ctl_code = ctl_idle_r;
        char_code_3c: ctl_code = ctl_3c;
        char_code_dc: ctl_code = ctl_dc;
        char_code_f7: ctl_code = ctl_f7;
        default:      ctl_code = ctl_error;
      endcase
  end

endmodule

// File: source/block_encoder.sv
`timescale 1ns/1ps

module block_encoder (
  input  logic                                                   CLK,
  input  logic                                                   reset,
  input  logic                                                   in_valid,
  input  logic [xgmii_pkg::lane_count*xgmii_pkg::lane_width-1:0] in_data,
  input  logic [xgmii_pkg::lane_count-1:0]                       in_ctrl,
  output logic                                                   blk_valid,
  output pcs_block_pkg::block_t                                  blk_block
);
  import xgmii_pkg::*;
  import pcs_block_pkg::*;

  localparam int code_w = $bits(ctl_code_t);
  // start and ordered sets are allowed at lanes 0 and 4 only.
  localparam logic [lane_count-1:0] off_lanes = 8'b1110_1110;

  lane_kind_t                   lane_kind [lane_count];
  logic [lane_count-1:0]        is_order;
  logic [lane_count-1:0]        is_fsig;
  logic [lane_count*code_w-1:0] codes;
  logic [lane_count-1:0]        data_l;
  logic [lane_count-1:0]        cntl_l;
  logic [lane_count-1:0]        term_l;
  logic [lane_count-1:0]        start_l;
  logic [lane_count-1:0]        term_fmt;
  logic                         pos_bad;
  logic [3:0]                   order0;
  logic [3:0]                   order4;
  logic [lane_count*code_w-1:0] term_field;
  block_type_t                  term_type;
  block_t                       blk_next;

  for (genvar i = 0; i < lane_count; i++)
  begin : g_lane
    localparam logic [lane_count-1:0] below = lane_count'((1 << i) - 1);
    localparam logic [lane_count-1:0] above = ~lane_count'((2 << i) - 1);

    control_lane_decoder decoder_i (
      .lane_char (in_data[i*lane_width +: lane_width]),
      .is_ctrl   (in_ctrl[i]),
      .lane_kind (lane_kind[i]),
      .is_order  (is_order[i]),
      .is_fsig   (is_fsig[i]),
      .ctl_code  (codes[i*code_w +: code_w])
    );

    assign data_l[i] = lane_kind[i] == kind_data;
    assign cntl_l[i] = lane_kind[i] == kind_ctrl && !is_order[i];
    assign term_l[i] = lane_kind[i] == kind_term;
    assign start_l[i] = lane_kind[i] == kind_start;
    // data below the terminate, control above it.
    assign term_fmt[i] = term_l[i] && &(data_l | ~below) && &(cntl_l | ~above);
  end

  assign pos_bad = |((start_l | is_order) & off_lanes);
  assign order0 = is_fsig[0] ? order_fsig : 4'h0;
  assign order4 = is_fsig[4] ? order_fsig : 4'h0;

  // data bytes sit at 8*lane, codes at 7*lane, padding between.
  always_comb
  begin
    term_type = type_term[0];
    term_field = '0;
    for (int t = 0; t < lane_count; t++)
      if (term_fmt[t])
      begin
        term_type = type_term[t];
        for (int i = 0; i < lane_count; i++)
          if (i < t)
            term_field[i*lane_width +: lane_width] = in_data[i*lane_width +: lane_width];
          else if (i > t)
            term_field[i*code_w +: code_w] = codes[i*code_w +: code_w];
      end
  end

  always_comb
  begin
    blk_next = {{lane_count{ctl_error}}, type_ctrl, sync_ctrl}; // error block.
    if (in_ctrl == '0)
      blk_next = {in_data, sync_data};
    else if (!pos_bad)
    begin
      if (&cntl_l)
        blk_next = {codes, type_ctrl, sync_ctrl};
      else if (&cntl_l[3:0] && is_order[4] && &data_l[7:5])
        blk_next = {in_data[63:40], order4, codes[27:0], type_ctrl_ord, sync_ctrl};
      else if (&cntl_l[3:0] && start_l[4] && &data_l[7:5])
        blk_next = {in_data[63:40], 4'h0, codes[27:0], type_ctrl_start, sync_ctrl};
      else if (is_order[0] && &data_l[3:1] && start_l[4] && &data_l[7:5])
        blk_next = {in_data[63:40], 4'h0, order0, in_data[31:8], type_ord_start, sync_ctrl};
      else if (is_order[0] && &data_l[3:1] && is_order[4] && &data_l[7:5])
        blk_next = {in_data[63:40], order4, order0, in_data[31:8], type_ord_ord, sync_ctrl};
      else if (start_l[0] && &data_l[7:1])
        blk_next = {in_data[63:8], type_start, sync_ctrl};
      else if (is_order[0] && &data_l[3:1] && &cntl_l[7:4])
        blk_next = {codes[55:28], order0, in_data[31:8], type_ord_ctrl, sync_ctrl};
      else if (|term_fmt)
        blk_next = {term_field, term_type, sync_ctrl};
    end
  end

  always_ff @(posedge CLK)
  begin
    if (reset)
      blk_valid <= 1'b0;
    else
      blk_valid <= in_valid;
    if (in_valid)
      blk_block <= blk_next;
  end

endmodule

// File: source/block_fifo.sv
`timescale 1ns/1ps

module block_fifo #(
  parameter int DEPTH = 4,
  parameter int WIDTH = 66
) (
  input  logic             CLK,
  input  logic             reset,
  input  logic             wr_valid,
  input  logic [WIDTH-1:0] wr_data,
  output logic             fifo_valid,
  output logic [WIDTH-1:0] fifo_data,
  input  logic             pop,
  output logic             credit
);

  localparam int ptr_w = DEPTH > 1 ? $clog2(DEPTH) : 1;
  localparam int cnt_w = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [ptr_w-1:0] rd_ptr;
  logic [ptr_w-1:0] wr_ptr;
  logic [cnt_w-1:0] count;
  logic             do_pop;

  function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
    if (ptr == ptr_w'(DEPTH - 1))
      return '0;
    return ptr + 1'b1;
  endfunction

  assign fifo_valid = count != '0;
  assign fifo_data = mem[rd_ptr];
  assign do_pop = pop && fifo_valid;
  assign credit = do_pop; // one credit per freed slot.

  always_ff @(posedge CLK)
  begin
    if (reset)
    begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count <= '0;
    end
    else
    begin
      if (wr_valid)
        wr_ptr <= next_ptr(wr_ptr);
      if (do_pop)
        rd_ptr <= next_ptr(rd_ptr);
      if (wr_valid && !do_pop)
        count <= count + 1'b1;
      else if (!wr_valid && do_pop)
        count <= count - 1'b1;
    end
    // space is guaranteed by the upstream credits.
    if (wr_valid)
      mem[wr_ptr] <= wr_data;
  end

endmodule

// File: source/block_scrambler.sv
`timescale 1ns/1ps

module block_scrambler #(
  parameter int OUT_CREDITS = 4
) (
  input  logic                  CLK,
  input  logic                  reset,
  input  logic                  fifo_valid,
  input  pcs_block_pkg::block_t fifo_block,
  output logic                  fifo_pop,
  input  logic                  out_credit,
  output logic                  out_valid,
  output pcs_block_pkg::block_t out_block
);
  import pcs_block_pkg::*;

  localparam int cnt_w = $clog2(OUT_CREDITS + 1);
  localparam int tap = 39; // x^39 term.
  localparam int chain_w = scram_width + payload_width;

  logic [cnt_w-1:0]       credits;
  logic [scram_width-1:0] state;
  // previous scrambled bits, then the new ones.
  logic [chain_w-1:0]     chain;

  assign fifo_pop = fifo_valid && credits != '0;

  always_comb
  begin
    chain = '0;
    chain[scram_width-1:0] = state;
    for (int i = 0; i < payload_width; i++)
      chain[scram_width + i] = fifo_block[2 + i] ^ chain[scram_width - tap + i] ^ chain[i];
  end

  always_ff @(posedge CLK)
  begin
    if (reset)
      credits <= cnt_w'(OUT_CREDITS);
    else if (fifo_pop && !out_credit)
      credits <= credits - 1'b1;
    else if (!fifo_pop && out_credit)
      credits <= credits + 1'b1;
  end

  always_ff @(posedge CLK)
  begin
    if (reset)
    begin
      out_valid <= 1'b0;
      state <= '0;
    end
    else
    begin
      out_valid <= fifo_pop;
      if (fifo_pop)
        state <= chain[chain_w-1 -: scram_width]; // last 58 scrambled bits.
    end
    if (fifo_pop)
      out_block <= {chain[chain_w-1 -: payload_width], fifo_block[1:0]};
  end

endmodule

// File: source/pcs_tx_top.sv
`timescale 1ns/1ps

module pcs_tx_top #(
  parameter int DEPTH = 4,
  parameter int OUT_CREDITS = 4
) (
  input  logic                                                   CLK,
  input  logic                                                   reset,
  input  logic                                                   in_valid,
  input  logic [xgmii_pkg::lane_count*xgmii_pkg::lane_width-1:0] in_data,
  input  logic [xgmii_pkg::lane_count-1:0]                       in_ctrl,
  output logic                                                   in_credit,
  input  logic                                                   out_credit,
  output logic                                                   out_valid,
  output pcs_block_pkg::block_t                                  out_block
);
  import pcs_block_pkg::*;

  logic   blk_valid;
  block_t blk_block;
  logic   fifo_valid;
  block_t fifo_block;
  logic   fifo_pop;

  block_encoder block_encoder_i (
    .CLK       (CLK),
    .reset     (reset),
    .in_valid  (in_valid),
    .in_data   (in_data),
    .in_ctrl   (in_ctrl),
    .blk_valid (blk_valid),
    .blk_block (blk_block)
  );

  // its depth is also the source's initial credit count.
  block_fifo #(
    .DEPTH (DEPTH),
    .WIDTH (block_width)
  ) block_fifo_i (
    .CLK        (CLK),
    .reset      (reset),
    .wr_valid   (blk_valid),
    .wr_data    (blk_block),
    .fifo_valid (fifo_valid),
    .fifo_data  (fifo_block),
    .pop        (fifo_pop),
    .credit     (in_credit)
  );

  block_scrambler #(
    .OUT_CREDITS (OUT_CREDITS)
  ) block_scrambler_i (
    .CLK        (CLK),
    .reset      (reset),
    .fifo_valid (fifo_valid),
    .fifo_block (fifo_block),
    .fifo_pop   (fifo_pop),
    .out_credit (out_credit),
    .out_valid  (out_valid),
    .out_block  (out_block)
  );

endmodule

// File: test/tb_pcs_tx_ref.svh
`ifndef TB_PCS_TX_REF_SVH
`define TB_PCS_TX_REF_SVH

// terminate type fields, lane 0 in the low byte.
localparam logic [63:0] term_codes = 64'hff_e1_d2_cc_b4_aa_99_87;

// scrambled history, newest bit in [0].
logic [scram_width-1:0] scr_hist = '0;

function automatic logic [6:0] code_of(input logic [7:0] c);
  case (c)
    char_idle:    return 7'h00;
    char_idle_a:  return 7'h4b;
    char_idle_k:  return 7'h55;
    char_idle_r:  return 7'h2d;
    char_code_3c: return 7'h33;
    char_code_dc: return 7'h66;
    char_code_f7: return 7'h78;
    default:      return 7'h1e;
  endcase
endfunction

// one letter per lane: D, C, S, T or O.
function automatic logic [7:0] lane_class(input logic [7:0] c, input logic k);
  if (!k)
    return "D";
  if (c == char_start)
    return "S";
  if (c == char_term)
    return "T";
  if (c == char_order || c == char_fsig)
    return "O";
  return "C";
endfunction

function automatic block_t encode_ref(input logic [63:0] d, input logic [7:0] k);
  logic [63:0] pat; // lane 0 in the top byte.
  logic [63:0] tpat;
  logic [55:0] pl;
  logic [7:0]  b [8];
  logic [6:0]  c [8];
  logic [3:0]  o [8];
  for (int i = 0; i < 8; i++)
  begin
    b[i] = d[8*i +: 8];
    c[i] = code_of(b[i]);
    o[i] = b[i] == char_fsig ? 4'hf : 4'h0;
    pat[63-8*i -: 8] = lane_class(b[i], k[i]);
  end
  if (k == 8'h00)
    return {d, sync_data};
  if (pat == "CCCCCCCC")
    return {c[7], c[6], c[5], c[4], c[3], c[2], c[1], c[0], 8'h1e, sync_ctrl};
  if (pat == "CCCCODDD")
    return {b[7], b[6], b[5], o[4], c[3], c[2], c[1], c[0], 8'h2d, sync_ctrl};
  if (pat == "CCCCSDDD")
    return {b[7], b[6], b[5], 4'h0, c[3], c[2], c[1], c[0], 8'h33, sync_ctrl};
  if (pat == "ODDDSDDD")
    return {b[7], b[6], b[5], 4'h0, o[0], b[3], b[2], b[1], 8'h66, sync_ctrl};
  if (pat == "ODDDODDD")
    return {b[7], b[6], b[5], o[4], o[0], b[3], b[2], b[1], 8'h55, sync_ctrl};
  if (pat == "SDDDDDDD")
    return {b[7], b[6], b[5], b[4], b[3], b[2], b[1], 8'h78, sync_ctrl};
  if (pat == "ODDDCCCC")
    return {c[7], c[6], c[5], c[4], o[0], b[3], b[2], b[1], 8'h4b, sync_ctrl};
  for (int t = 0; t < 8; t++)
  begin
    for (int i = 0; i < 8; i++)
      tpat[63-8*i -: 8] = i < t ? "D" : (i == t ? "T" : "C");
    if (pat == tpat)
    begin
      pl = '0;
      for (int i = 0; i < t; i++)
        pl[8*i +: 8] = b[i];
      for (int i = t + 1; i < 8; i++)
        pl[7*i +: 7] = c[i];
      return {pl, term_codes[8*t +: 8], sync_ctrl};
    end
  end
  return {{8{7'h1e}}, 8'h1e, sync_ctrl}; // no format matched.
endfunction

function automatic block_t scramble_ref(input block_t blk);
  block_t res;
  logic   s;
  res = blk;
  for (int i = 2; i < 66; i++)
  begin
    s = blk[i] ^ scr_hist[38] ^ scr_hist[57];
    res[i] = s;
    scr_hist = {scr_hist[56:0], s};
  end
  return res;
endfunction

`endif

// File: test/tb_pcs_tx.sv
`timescale 1ns/1ps

module tb_pcs_tx;
  import xgmii_pkg::*;
  import pcs_block_pkg::*;

  localparam int depth = 4;
  localparam int out_credits = 4;
  localparam int total_words = 267;
  localparam int max_cycles = 8 * total_words + 200;
  localparam logic [63:0] plain_chars = {char_error, char_code_f7, char_code_dc, char_code_3c,
                                         char_idle_r, char_idle_k, char_idle_a, char_idle};

  `include "tb_pcs_tx_ref.svh"

  logic        CLK;
  logic        reset;
  logic        in_valid;
  logic [63:0] in_data;
  logic [7:0]  in_ctrl;
  logic        in_credit;
  logic        out_credit;
  logic        out_valid;
  block_t      out_block;

  logic [71:0] sent_q [$]; // {ctrl, data}.
  int src_credits = depth;
  int in_flight = 0;
  int pops_seen = 0;
  int blocks_out = 0;
  int returns_seen = 0;
  int returns_sent = 0;
  int words_sent = 0;
  int cycles = 0;
  bit withhold = 1'b0;

  pcs_tx_top #(
    .DEPTH       (depth),
    .OUT_CREDITS (out_credits)
  ) pcs_tx_top_i (
    .CLK        (CLK),
    .reset      (reset),
    .in_valid   (in_valid),
    .in_data    (in_data),
    .in_ctrl    (in_ctrl),
    .in_credit  (in_credit),
    .out_credit (out_credit),
    .out_valid  (out_valid),
    .out_block  (out_block)
  );

  initial
  begin
    CLK = 1'b0;
    forever #5 CLK = ~CLK;
  end

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("FAIL: see errors above");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_value(input string name, input logic [127:0] got,
                             input logic [127:0] exp);
    if (got !== exp)
      fail_run($sformatf("mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp));
  endtask

  task automatic send_word(input logic [63:0] d, input logic [7:0] k);
    @(posedge CLK);
    #1;
    while (src_credits == 0)
    begin
      in_valid = 1'b0; // out of credits.
      @(posedge CLK);
      #1;
    end
    in_valid = 1'b1;
    in_data = d;
    in_ctrl = k;
    src_credits--;
    words_sent++;
    sent_q.push_back({k, d});
  endtask

  // data below lane t, idles above.
  task automatic terminate_at(input int t);
    logic [63:0] d;
    d = {$urandom, $urandom};
    for (int i = t; i < 8; i++)
      d[8*i +: 8] = i == t ? char_term : char_idle;
    send_word(d, 8'hff << t);
  endtask

  task automatic random_traffic(input int n);
    int kind;
    repeat (n)
    begin
      kind = $urandom % 10;
      if (kind < 8)
        terminate_at(kind);
      else if (kind == 8)
        send_word({$urandom, $urandom}, 8'h00);
      else
        send_word({{7{char_idle}}, char_start}, 8'hff);
    end
  endtask

  // credit return to the DUT, only for blocks already taken.
  initial
  begin
    out_credit = 1'b0;
    forever
    begin
      @(posedge CLK);
      #1;
      out_credit = 1'b0;
      if (!reset && !withhold && blocks_out > returns_sent && $urandom % 2 == 0)
      begin
        out_credit = 1'b1;
        returns_sent++;
      end
    end
  end

  always @(negedge CLK)
  begin
    logic [71:0] w;
    cycles++;
    if (cycles > max_cycles)
      fail_run("timeout: the run went past its cycle limit");
    if (in_valid)
      in_flight++;
    if (in_credit)
    begin
      src_credits++;
      in_flight--;
      pops_seen++;
    end
    if (in_flight < 0)
      fail_run("in_credit pulsed with no word in flight");
    if (in_flight > depth)
      fail_run("the source sent more words than it held credits for");
    if (out_valid)
    begin
      if (sent_q.size() == 0)
        fail_run("out_valid was high with no word outstanding");
      w = sent_q.pop_front();
      check_value("out_block", out_block, scramble_ref(encode_ref(w[63:0], w[71:64])));
      blocks_out++;
    end
    if (pops_seen > out_credits + returns_seen || blocks_out > out_credits + returns_seen)
      fail_run("the DUT sent a block without an output credit");
    if (out_credit)
      returns_seen++; // usable from the next cycle.
  end

  initial
  begin
    logic [63:0] r;
    int          p;
    void'($urandom(43));
    reset = 1'b1;
    in_valid = 1'b0;
    in_data = '0;
    in_ctrl = '0;
    repeat (2) @(posedge CLK);
    #1;
    reset = 1'b0;
    check_value("out_valid", out_valid, 0);
    check_value("in_credit", in_credit, 0);

    repeat (200) send_word({$urandom, $urandom}, 8'h00);
    for (int i = 0; i < 8; i++)
      send_word({8{plain_chars[8*i +: 8]}}, 8'hff);

    r = {$urandom, $urandom};
    send_word({r[63:8], char_start}, 8'h01);
    send_word({r[63:40], char_start, {4{char_idle}}}, 8'h1f);
    for (int t = 0; t < 8; t++)
      terminate_at(t);

    r = {$urandom, $urandom};
    send_word({r[63:40], char_fsig, {4{char_idle}}}, 8'h1f);
    send_word({r[31:8], char_order, char_idle_r, char_idle_k, char_idle_a, char_idle}, 8'h1f);
    send_word({r[63:40], char_order, r[31:8], char_fsig}, 8'h11);
    send_word({r[63:40], char_start, r[31:8], char_fsig}, 8'h11);
    send_word({{4{char_idle}}, r[31:8], char_order}, 8'hf1);

    // invalid words.
    r = {$urandom, $urandom};
    send_word({r[63:24], char_start, r[15:0]}, 8'h04);
    send_word({r[63:32], 8'h42, r[23:0]}, 8'h08);
    send_word({8{8'h42}}, 8'hff);
    send_word({char_idle, char_idle, r[47:40], char_idle, char_term, r[23:0]}, 8'hd8);

    @(negedge CLK);
    withhold = 1'b1;
    fork
      begin
        repeat (30) @(posedge CLK);
        p = pops_seen;
        repeat (20) @(posedge CLK);
        check_value("in_credit pulses", pops_seen, p);
        check_value("in_flight", in_flight, depth);
        @(negedge CLK);
        withhold = 1'b0;
      end
      random_traffic(40);
    join

    @(posedge CLK);
    #1;
    in_valid = 1'b0;
    while (sent_q.size() != 0)
      @(posedge CLK);
    check_value("in_credit total", pops_seen, words_sent); // one credit back per word.
    $display("PASS: all tests");
    $finish;
  end

endmodule

// File: vlog.f
+incdir+test
source/xgmii_pkg.sv
source/pcs_block_pkg.sv
source/control_lane_decoder.sv
source/block_encoder.sv
source/block_fifo.sv
source/block_scrambler.sv
source/pcs_tx_top.sv
test/tb_pcs_tx.sv

// File: Makefile
.PHONY: all run lint clean

all: run

obj_dir/sim: vlog.f $(wildcard source/*.sv) $(wildcard test/*.sv) $(wildcard test/*.svh)
	verilator --binary --timing -Wno-fatal -f vlog.f --top-module tb_pcs_tx -o sim

# the log decides pass or fail.
run: obj_dir/sim
	./obj_dir/sim | tee sim.log
	grep -q "PASS: all tests" sim.log

lint:
	verilator --lint-only -Wall --timing -f vlog.f --top-module tb_pcs_tx
	verilator --lint-only -Wall source/xgmii_pkg.sv source/pcs_block_pkg.sv \
		source/control_lane_decoder.sv source/block_encoder.sv source/block_fifo.sv \
		source/block_scrambler.sv source/pcs_tx_top.sv --top-module pcs_tx_top

clean:
	rm -rf obj_dir sim.log
